//--- hdl/memSys_params.svh
`ifndef MEMSYS_PARAMS_SVH
`define MEMSYS_PARAMS_SVH

// data and instruction width
`define XLEN 32

// byte-wide ram, 4 KiB
`define BYTE_W 8
`define MEM_ADDR_W 12

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- hdl/memPkg.sv
`include "memSys_params.svh"

package memPkg;

    typedef enum logic {
        LS_LOAD  = 1'b0,
        LS_STORE = 1'b1
    } lsKind_e;

    // 2'b11 is not a legal size
    typedef enum logic [1:0] {
        LEN_BYTE = 2'b00,
        LEN_HALF = 2'b01,
        LEN_WORD = 2'b10
    } accessLen_e;

    typedef struct packed {
        lsKind_e           kind;
        accessLen_e        len;
        logic              isSigned;
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  wdata;
    } memReq_t;

    typedef struct packed {
        logic                   we;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`BYTE_W-1:0]     wdata;
    } ramPort_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } fetchOut_t;

endpackage

//--- hdl/byteRam.sv
`timescale 1ns/1ps
`include "memSys_params.svh"

module byteRam (
    input  logic               clk,
    input  memPkg::ramPort_t   i_port,
    output logic [`BYTE_W-1:0] o_rdata
);
    localparam int DEPTH = 1 << `MEM_ADDR_W;

    logic [`BYTE_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_port.we) begin
            mem[i_port.addr] <= i_port.wdata;
        end
    end

    // read every cycle, one clock of latency
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_port.addr];
    end

endmodule

//--- hdl/memCtrl.sv
`timescale 1ns/1ps
`include "memSys_params.svh"

module memCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_rdy,
    input  logic               i_ioFull,
    input  logic               i_fetchReq,
    input  logic [`XLEN-1:0]   i_fetchAddr,
    output logic               o_instDone,
    output logic [`XLEN-1:0]   o_inst,
    input  logic               i_dataReq,
    input  memPkg::memReq_t    i_dataReqInfo,
    output logic               o_dataDone,
    output logic [`XLEN-1:0]   o_dataRaw,
    output memPkg::ramPort_t   o_ram,
    input  logic [`BYTE_W-1:0] i_ramData
);
    localparam int ASM_W = `XLEN - `BYTE_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD_INST,
        ST_RD_DATA,
        ST_WR_DATA
    } ctrlState_e;

    ctrlState_e              state;
    logic [2:0]              stage;
    logic [`MEM_ADDR_W-1:0]  curAddr;
    memPkg::accessLen_e      curLen;
    logic [`XLEN-1:0]        curWdata;
    logic [ASM_W-1:0]        asmReg;
    logic                    frozen;
    logic                    reading;
    logic                    readDone;
    logic                    writeDone;
    logic [1:0]              lastIdx;
    logic [2:0]              seqIdx;
    logic [1:0]              byteOff;
    logic [`XLEN-1:0]        wordShift;

    function automatic logic [1:0] lastByteOf(input memPkg::accessLen_e len);
        case (len)
            memPkg::LEN_BYTE: return 2'd0;
            memPkg::LEN_HALF: return 2'd1;
            default:          return 2'd3;
        endcase
    endfunction

    assign frozen    = !i_rdy || i_ioFull;
    assign reading   = (state == ST_RD_INST) || (state == ST_RD_DATA);
    assign lastIdx   = lastByteOf(curLen);
    // stage counts cycles since acceptance, starting at 1
    assign readDone  = reading && (stage == {1'b0, lastIdx} + 3'd2);
    assign writeDone = (state == ST_WR_DATA) && (stage == {1'b0, lastIdx} + 3'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            stage <= 3'd0;
        end else if (!frozen) begin
            case (state)
                ST_IDLE: begin
                    stage <= 3'd1;
                    // data side wins a tie
                    if (i_dataReq) begin
                        if (i_dataReqInfo.kind == memPkg::LS_STORE) begin
                            state <= ST_WR_DATA;
                        end else begin
                            state <= ST_RD_DATA;
                        end
                    end else if (i_fetchReq) begin
                        state <= ST_RD_INST;
                    end
                end
                default: begin
                    if (readDone || writeDone) begin
                        state <= ST_IDLE;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!frozen) begin
            if (state == ST_IDLE) begin
                if (i_dataReq) begin
                    curAddr  <= i_dataReqInfo.addr[`MEM_ADDR_W-1:0];
                    curLen   <= i_dataReqInfo.len;
                    curWdata <= i_dataReqInfo.wdata;
                end else begin
                    curAddr <= i_fetchAddr[`MEM_ADDR_W-1:0];
                    curLen  <= memPkg::LEN_WORD;
                end
            end else if (reading && (stage <= {1'b0, lastIdx})) begin
                // last byte is never stored, it is merged at done
                case (stage)
                    3'd1:    asmReg[`BYTE_W-1:0]            <= i_ramData;
                    3'd2:    asmReg[2*`BYTE_W-1:`BYTE_W]    <= i_ramData;
                    3'd3:    asmReg[3*`BYTE_W-1:2*`BYTE_W]  <= i_ramData;
                    default: asmReg                         <= asmReg;
                endcase
            end
        end
    end

    // byte offset on the ram port
    always_comb begin
        if ((state == ST_WR_DATA) || frozen) begin
            // a frozen read re-issues the previous address
            seqIdx = stage - 3'd1;
        end else begin
            seqIdx = stage;
        end
        if (seqIdx > {1'b0, lastIdx}) begin
            seqIdx = {1'b0, lastIdx};
        end
        byteOff   = seqIdx[1:0];
        wordShift = curWdata >> {byteOff, 3'b000};
    end

    always_comb begin
        o_ram.we    = 1'b0;
        o_ram.addr  = curAddr + {{(`MEM_ADDR_W-2){1'b0}}, byteOff};
        o_ram.wdata = wordShift[`BYTE_W-1:0];
        if (state == ST_IDLE) begin
            // first read address goes out in the acceptance cycle
            if (i_dataReq) begin
                o_ram.addr = i_dataReqInfo.addr[`MEM_ADDR_W-1:0];
            end else begin
                o_ram.addr = i_fetchAddr[`MEM_ADDR_W-1:0];
            end
        end else if (state == ST_WR_DATA) begin
            o_ram.we = !frozen;
        end
    end

    always_comb begin
        o_instDone = (state == ST_RD_INST) && readDone && !frozen;
        o_dataDone = (((state == ST_RD_DATA) && readDone) || writeDone) && !frozen;
        o_inst     = {i_ramData, asmReg};
        case (curLen)
            memPkg::LEN_BYTE: o_dataRaw = {{ASM_W{1'b0}}, i_ramData};
            memPkg::LEN_HALF: o_dataRaw = {{(`XLEN-2*`BYTE_W){1'b0}}, i_ramData,
                                           asmReg[`BYTE_W-1:0]};
            default:          o_dataRaw = {i_ramData, asmReg};
        endcase
    end

    // requesters hold their level until done
    assert property (@(posedge clk) disable iff (rst)
        ((state == ST_RD_DATA) || (state == ST_WR_DATA)) |-> i_dataReq);

    assert property (@(posedge clk) disable iff (rst)
        (state == ST_RD_INST) |-> i_fetchReq);

    // requester must never present the reserved size
    assert property (@(posedge clk) disable iff (rst)
        ((state == ST_IDLE) && !frozen && i_dataReq) |->
        (i_dataReqInfo.len inside {memPkg::LEN_BYTE, memPkg::LEN_HALF, memPkg::LEN_WORD}));

endmodule

//--- hdl/instFetch.sv
`timescale 1ns/1ps
`include "memSys_params.svh"

module instFetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_queueFull,
    input  logic              i_redirect,
    input  logic [`XLEN-1:0]  i_redirectPc,
    output logic              o_fetchReq,
    output logic [`XLEN-1:0]  o_fetchAddr,
    input  logic              i_instDone,
    input  logic [`XLEN-1:0]  i_inst,
    output logic              o_instValid,
    output memPkg::fetchOut_t o_fetch
);
    localparam logic [`XLEN-1:0] INST_BYTES = 4;

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] nextPc;
    logic             reqActive;
    logic             discard;
    logic             acceptInst;
    logic             canIssue;

    // a redirect in the done cycle also drops the word
    assign acceptInst = i_instDone && !discard && !i_redirect;
    assign canIssue   = (!reqActive || i_instDone) && !i_queueFull;
    assign o_fetchReq = reqActive;

    always_comb begin
        if (i_redirect) begin
            nextPc = i_redirectPc;
        end else if (acceptInst) begin
            nextPc = o_fetchAddr + INST_BYTES;
        end else begin
            nextPc = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RESET_PC;
            reqActive   <= 1'b0;
            discard     <= 1'b0;
            o_instValid <= 1'b0;
        end else begin
            pc          <= nextPc;
            o_instValid <= acceptInst;
            if (canIssue) begin
                reqActive <= 1'b1;
            end else if (i_instDone) begin
                reqActive <= 1'b0;
            end
            // old-path fetch still has to run to its done
            if (i_instDone) begin
                discard <= 1'b0;
            end else if (i_redirect && reqActive) begin
                discard <= 1'b1;
            end
        end
    end

    // address stays stable while the request is up
    always_ff @(posedge clk) begin
        if (canIssue) begin
            o_fetchAddr <= nextPc;
        end
        if (acceptInst) begin
            o_fetch.pc   <= o_fetchAddr;
            o_fetch.inst <= i_inst;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (i_instDone && discard) |=> !o_instValid);

endmodule

//--- hdl/loadStoreUnit.sv
`timescale 1ns/1ps
`include "memSys_params.svh"

module loadStoreUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_lsValid,
    input  memPkg::memReq_t  i_lsOp,
    output logic             o_lsBusy,
    output logic             o_dataReq,
    output memPkg::memReq_t  o_dataReqInfo,
    input  logic             i_dataDone,
    input  logic [`XLEN-1:0] i_dataRaw,
    output logic             o_lsDone,
    output logic [`XLEN-1:0] o_loadData
);
    logic            busy;
    memPkg::memReq_t opReg;
    logic            signBit;

    assign o_lsBusy      = busy;
    assign o_dataReq     = busy;
    assign o_dataReqInfo = opReg;
    assign o_lsDone      = busy && i_dataDone;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (!busy && i_lsValid) begin
            busy <= 1'b1;
        end else if (i_dataDone) begin
            // request level drops right after done
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && i_lsValid) begin
            opReg <= i_lsOp;
        end
    end

    // raw data arrives right-aligned with zero upper bytes
    always_comb begin
        case (opReg.len)
            memPkg::LEN_BYTE: begin
                signBit    = opReg.isSigned && i_dataRaw[`BYTE_W-1];
                o_loadData = {{(`XLEN-`BYTE_W){signBit}}, i_dataRaw[`BYTE_W-1:0]};
            end
            memPkg::LEN_HALF: begin
                signBit    = opReg.isSigned && i_dataRaw[2*`BYTE_W-1];
                o_loadData = {{(`XLEN-2*`BYTE_W){signBit}}, i_dataRaw[2*`BYTE_W-1:0]};
            end
            default: begin
                signBit    = 1'b0;
                o_loadData = i_dataRaw;
            end
        endcase
    end

    // one operation at a time, caller waits for done
    assert property (@(posedge clk) disable iff (rst)
        busy |-> !i_lsValid);

endmodule

//--- hdl/memSubsystem.sv
`timescale 1ns/1ps
`include "memSys_params.svh"

module memSubsystem (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rdy,
    input  logic              i_ioFull,
    input  logic              i_queueFull,
    input  logic              i_redirect,
    input  logic [`XLEN-1:0]  i_redirectPc,
    input  logic              i_lsValid,
    input  memPkg::memReq_t   i_lsOp,
    output logic              o_lsBusy,
    output logic              o_lsDone,
    output logic [`XLEN-1:0]  o_loadData,
    output logic              o_instValid,
    output memPkg::fetchOut_t o_fetch
);
    logic               fetchReq;
    logic [`XLEN-1:0]   fetchAddr;
    logic               instDone;
    logic [`XLEN-1:0]   inst;
    logic               dataReq;
    memPkg::memReq_t    dataReqInfo;
    logic               dataDone;
    logic [`XLEN-1:0]   dataRaw;
    memPkg::ramPort_t   ramCmd;
    logic [`BYTE_W-1:0] ramData;

    memCtrl uMemCtrl (
        .clk           (clk),
        .rst           (rst),
        .i_rdy         (i_rdy),
        .i_ioFull      (i_ioFull),
        .i_fetchReq    (fetchReq),
        .i_fetchAddr   (fetchAddr),
        .o_instDone    (instDone),
        .o_inst        (inst),
        .i_dataReq     (dataReq),
        .i_dataReqInfo (dataReqInfo),
        .o_dataDone    (dataDone),
        .o_dataRaw     (dataRaw),
        .o_ram         (ramCmd),
        .i_ramData     (ramData)
    );

    instFetch uInstFetch (
        .clk          (clk),
        .rst          (rst),
        .i_queueFull  (i_queueFull),
        .i_redirect   (i_redirect),
        .i_redirectPc (i_redirectPc),
        .o_fetchReq   (fetchReq),
        .o_fetchAddr  (fetchAddr),
        .i_instDone   (instDone),
        .i_inst       (inst),
        .o_instValid  (o_instValid),
        .o_fetch      (o_fetch)
    );

    loadStoreUnit uLoadStoreUnit (
        .clk           (clk),
        .rst           (rst),
        .i_lsValid     (i_lsValid),
        .i_lsOp        (i_lsOp),
        .o_lsBusy      (o_lsBusy),
        .o_dataReq     (dataReq),
        .o_dataReqInfo (dataReqInfo),
        .i_dataDone    (dataDone),
        .i_dataRaw     (dataRaw),
        .o_lsDone      (o_lsDone),
        .o_loadData    (o_loadData)
    );

    byteRam uByteRam (
        .clk     (clk),
        .i_port  (ramCmd),
        .o_rdata (ramData)
    );

endmodule

//--- bench/memSubsystemTb.sv
`timescale 1ns/1ps
`include "memSys_params.svh"

module memSubsystemTb;
    localparam int FETCH_WORDS = 8;

    logic              clk;
    logic              rst;
    logic              i_rdy;
    logic              i_ioFull;
    logic              i_queueFull;
    logic              i_redirect;
    logic [`XLEN-1:0]  i_redirectPc;
    logic              i_lsValid;
    memPkg::memReq_t   i_lsOp;
    logic              o_lsBusy;
    logic              o_lsDone;
    logic [`XLEN-1:0]  o_loadData;
    logic              o_instValid;
    memPkg::fetchOut_t o_fetch;

    logic [`BYTE_W-1:0] refMem [1 << `MEM_ADDR_W];
    logic [31:0]        lfsr;
    logic [`XLEN-1:0]   fetchBase;
    logic [`XLEN-1:0]   expPc;
    int                 fetchCount;
    int                 windowsDone;
    logic               needRedirect;
    logic               watchFetch;

    memSubsystem UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int lenBytes(input memPkg::accessLen_e len);
        case (len)
            memPkg::LEN_BYTE: return 1;
            memPkg::LEN_HALF: return 2;
            default:          return 4;
        endcase
    endfunction

    // little-endian bytes from the reference, then sign or zero fill
    function automatic logic [31:0] refValue(input logic [31:0] addr, input int n,
                                             input logic sgn);
        logic [31:0]            v;
        logic [`MEM_ADDR_W-1:0] a;
        int                     i;
        v = '0;
        for (i = 0; i < n; i++) begin
            a           = addr[`MEM_ADDR_W-1:0] + i;
            v[8*i +: 8] = refMem[a];
        end
        if (sgn && (n < 4) && v[8*n-1]) begin
            v = v | (32'hffff_ffff << (8 * n));
        end
        return v;
    endfunction

    task automatic stopRun(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // starts at posedge + 1 ns with the unit idle, returns the same way
    task automatic runLsOp(input memPkg::lsKind_e opKind, input memPkg::accessLen_e opLen,
                           input logic sgn, input logic [31:0] addr, input logic [31:0] wdata,
                           input bit checkLat, input int frzStart, input int frzLen);
        int                     n;
        int                     i;
        int                     cycles;
        int                     expLat;
        logic [31:0]            expData;
        logic [`MEM_ADDR_W-1:0] a;
        logic                   frz;
        logic                   useIoFull;
        bit                     done;
        n         = lenBytes(opLen);
        expData   = refValue(addr, n, sgn);
        expLat    = n + ((opKind == memPkg::LS_LOAD) ? 2 : 1) + frzLen;
        useIoFull = randBits(1);
        i_lsOp    = '{kind: opKind, len: opLen, isSigned: sgn, addr: addr, wdata: wdata};
        i_lsValid = 1'b1;
        @(posedge clk);
        #1;
        i_lsValid = 1'b0;
        cycles    = 1;
        done      = 1'b0;
        while (!done) begin
            frz      = (cycles >= frzStart) && (cycles < frzStart + frzLen);
            i_ioFull = frz && useIoFull;
            i_rdy    = !(frz && !useIoFull);
            @(negedge clk);
            if (o_lsDone) begin
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles > 200) begin
                    stopRun("timeout waiting for a load or store to finish");
                end
                @(posedge clk);
                #1;
            end
        end
        assert (!frz) else
            stopRun($sformatf("ERR %0t: done pulsed while frozen", $time));
        assert (!checkLat || (cycles == expLat)) else
            stopRun($sformatf("ERR %0t: done after %0d cycles, expected %0d",
                              $time, cycles, expLat));
        assert ((opKind == memPkg::LS_STORE) || (o_loadData === expData)) else
            stopRun($sformatf("ERR %0t: load at %h returned %h, expected %h",
                              $time, addr, o_loadData, expData));
        if (opKind == memPkg::LS_STORE) begin
            for (i = 0; i < n; i++) begin
                a         = addr[`MEM_ADDR_W-1:0] + i;
                refMem[a] = wdata[8*i +: 8];
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic storeAndReload(input bit checkLat, input bit withFreeze);
        memPkg::accessLen_e len;
        logic [31:0]        addr;
        int                 n;
        int                 frzStart;
        int                 frzLen;
        len      = memPkg::accessLen_e'(randBits(2) % 3);
        addr     = randBits(11);
        n        = lenBytes(len);
        frzStart = 1 + randBits(3) % (n + 1);
        frzLen   = withFreeze ? 1 + randBits(3) : 0;
        runLsOp(memPkg::LS_STORE, len, 1'b0, addr, randBits(32), checkLat, frzStart, frzLen);
        frzStart = 1 + randBits(3) % (n + 1);
        runLsOp(memPkg::LS_LOAD, len, randBits(1), addr, '0, checkLat, frzStart, frzLen);
    endtask

    task automatic roundTrip();
        logic [31:0] addr [3];
        int          i;
        int          k;
        for (k = 0; k < 2; k++) begin
            // word, half, byte
            for (i = 0; i < 3; i++) begin
                addr[i] = randBits(11);
                runLsOp(memPkg::LS_STORE, memPkg::accessLen_e'(2 - i), 1'b0, addr[i],
                        randBits(32), 1'b1, 0, 0);
            end
            for (i = 0; i < 3; i++) begin
                runLsOp(memPkg::LS_LOAD, memPkg::accessLen_e'(2 - i), 1'b0, addr[i],
                        '0, 1'b1, 0, 0);
            end
        end
    endtask

    task automatic signExtension();
        memPkg::accessLen_e len;
        logic [31:0]        addr;
        logic [31:0]        data;
        int                 i;
        for (i = 0; i < 4; i++) begin
            len  = (i < 2) ? memPkg::LEN_BYTE : memPkg::LEN_HALF;
            addr = randBits(11);
            data = randBits(32);
            data[8*lenBytes(len)-1] = i[0];
            runLsOp(memPkg::LS_STORE, len, 1'b0, addr, data, 1'b1, 0, 0);
            runLsOp(memPkg::LS_LOAD, len, 1'b1, addr, '0, 1'b1, 0, 0);
            runLsOp(memPkg::LS_LOAD, len, 1'b0, addr, '0, 1'b1, 0, 0);
        end
    endtask

    task automatic latencyCheck();
        logic [31:0] addr;
        int          i;
        for (i = 0; i < 3; i++) begin
            addr = randBits(11);
            runLsOp(memPkg::LS_STORE, memPkg::accessLen_e'(i), 1'b0, addr, randBits(32),
                    1'b1, 0, 0);
            runLsOp(memPkg::LS_LOAD, memPkg::accessLen_e'(i), 1'b0, addr, '0, 1'b1, 0, 0);
        end
    endtask

    task automatic waitWindows(input int target);
        int waited;
        waited = 0;
        while (windowsDone < target) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 2000) begin
                stopRun("timeout waiting for fetched instructions");
            end
        end
    endtask

    task automatic fetchStream();
        int i;
        // window sits above the data area
        fetchBase = 32'h0000_0f00 + (randBits(5) << 2);
        for (i = 0; i < FETCH_WORDS; i++) begin
            runLsOp(memPkg::LS_STORE, memPkg::LEN_WORD, 1'b0, fetchBase + 4 * i,
                    randBits(32), 1'b1, 0, 0);
        end
        expPc        = fetchBase;
        fetchCount   = 0;
        watchFetch   = 1'b1;
        needRedirect = 1'b1;
        i_queueFull  = 1'b0;
        waitWindows(2);
    endtask

    task automatic freezeDuringOps();
        repeat (8) storeAndReload(1'b0, 1'b1);
    endtask

    task automatic arbitration();
        int start;
        start = windowsDone;
        repeat (10) storeAndReload(1'b0, 1'b0);
        waitWindows(start + 1);
    endtask

    // fetched words must follow the window from its base
    always @(negedge clk) begin
        if (watchFetch && o_instValid) begin
            assert ((o_fetch.pc === expPc) && (o_fetch.inst === refValue(expPc, 4, 1'b0)))
            else
                stopRun($sformatf("ERR %0t: fetch pc %h inst %h, expected pc %h inst %h",
                                  $time, o_fetch.pc, o_fetch.inst, expPc,
                                  refValue(expPc, 4, 1'b0)));
            expPc = expPc + 4;
            fetchCount++;
            if (fetchCount == FETCH_WORDS) begin
                windowsDone++;
                needRedirect = 1'b1;
            end
        end
    end

    // jump back to the window base, usually with the next fetch in flight
    always @(posedge clk) begin
        #1;
        if (needRedirect) begin
            i_redirect   = 1'b1;
            i_redirectPc = fetchBase;
            expPc        = fetchBase;
            fetchCount   = 0;
            needRedirect = 1'b0;
        end else begin
            i_redirect = 1'b0;
        end
    end

    initial begin
        lfsr         = 32'h3baf54cc;
        rst          = 1'b1;
        i_rdy        = 1'b1;
        i_ioFull     = 1'b0;
        i_queueFull  = 1'b1;
        i_redirect   = 1'b0;
        i_redirectPc = '0;
        i_lsValid    = 1'b0;
        i_lsOp       = '0;
        fetchBase    = '0;
        expPc        = '0;
        fetchCount   = 0;
        windowsDone  = 0;
        needRedirect = 1'b0;
        watchFetch   = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!o_lsBusy && !o_lsDone && !o_instValid) else
            stopRun($sformatf("ERR %0t: strobes or busy high after reset", $time));
        roundTrip();
        signExtension();
        latencyCheck();
        fetchStream();
        freezeDuringOps();
        arbitration();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/memPkg.sv
hdl/byteRam.sv
hdl/memCtrl.sv
hdl/instFetch.sv
hdl/loadStoreUnit.sv
hdl/memSubsystem.sv
bench/memSubsystemTb.sv
